// File: project.f
+incdir+test
src/rv_exec_pkg.sv
src/instr_decoder.sv
src/alu_execute.sv
src/writeback_select.sv
src/rv_exec_top.sv
test/tb_rv_exec.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_rv_exec -f project.f -o sim_tb \
	|| { echo "build failed"; exit 1; }

./obj_dir/sim_tb | tee /dev/stderr | grep "=== PASS ===" > /dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// File: test/tb_rv_exec_tasks.svh
// instruction encoders, rs1 = x1, rs2 = x2, rd = x5
function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3);
	return {f7, 5'd2, 5'd1, f3, 5'd5, 7'b0110011};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3,
		input logic [6:0] op);
	return {imm, 5'd1, f3, 5'd5, op};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [2:0] f3);
	return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [2:0] f3);
	return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm);
	return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd5, 7'b1101111};
endfunction

// rv32i integer ops by funct3, alt selects sub / sra
function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
	case (f3)
		3'd0: return alt ? a - b : a + b;
		3'd1: return a << b[4:0];
		3'd2: return {31'b0, $signed(a) < $signed(b)};
		3'd3: return {31'b0, a < b};
		3'd4: return a ^ b;
		3'd5: begin
			if (alt)
				return $signed(a) >>> b[4:0];
			return a >> b[4:0];
		end
		3'd6: return a | b;
		default: return a & b;
	endcase
endfunction

function automatic exp_t ref_exec(input exec_req_t q);
	exp_t        e;
	logic [31:0] ins, ii, is, ib, iu, ij, a, b;
	logic [2:0]  f3;
	logic [6:0]  f7;
	logic        ill, tk;
	ins = q.instr;
	a   = q.rs1_val;
	b   = q.rs2_val;
	f3  = ins[14:12];
	f7  = ins[31:25];
	ii  = {{20{ins[31]}}, ins[31:20]};
	is  = {{20{ins[31]}}, ins[31:25], ins[11:7]};
	ib  = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
	iu  = {ins[31:12], 12'b0};
	ij  = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
	e   = '0;
	ill = 1'b0;
	tk  = 1'b0;
	e.r.rd         = ins[11:7];
	e.r.next_pc    = q.pc + 32'd4;
	e.r.store_data = b;
	e.r.mem_op     = MEM_NONE;
	e.r.exc        = EXC_NONE;
	case (ins[6:0])
		7'b0110011: begin
			ill = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
			e.r.rd_we  = 1'b1;
			e.r.wb_val = alu_ref(f3, ins[30], a, b);
		end
		7'b0010011: begin
			ill = (f3 == 3'd1 && f7 != 7'h00) || (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
			e.r.rd_we  = 1'b1;
			e.r.wb_val = alu_ref(f3, f3 == 3'd5 && ins[30], a, ii);
		end
		7'b0000011: begin
			e.r.rd_we  = 1'b1;
			e.r.wb_val = a + ii;
			case (f3)
				3'd0: e.r.mem_op = MEM_LB;
				3'd1: e.r.mem_op = MEM_LH;
				3'd2: e.r.mem_op = MEM_LW;
				3'd4: e.r.mem_op = MEM_LBU;
				3'd5: e.r.mem_op = MEM_LHU;
				default: ill = 1'b1;
			endcase
		end
		7'b0100011: begin
			// the address is still reported for a store
			e.chk_wb   = 1'b1;
			e.r.wb_val = a + is;
			case (f3)
				3'd0: e.r.mem_op = MEM_SB;
				3'd1: e.r.mem_op = MEM_SH;
				3'd2: e.r.mem_op = MEM_SW;
				default: ill = 1'b1;
			endcase
		end
		7'b1100011: begin
			case (f3)
				3'd0: tk = a == b;
				3'd1: tk = a != b;
				3'd4: tk = $signed(a) < $signed(b);
				3'd5: tk = $signed(a) >= $signed(b);
				3'd6: tk = a < b;
				3'd7: tk = a >= b;
				default: ill = 1'b1;
			endcase
			if (tk)
				e.r.next_pc = q.pc + ib;
		end
		7'b1101111: begin
			e.r.rd_we   = 1'b1;
			e.r.wb_val  = q.pc + 32'd4;
			e.r.next_pc = q.pc + ij;
		end
		7'b1100111: begin
			ill         = f3 != 3'd0;
			e.r.rd_we   = 1'b1;
			e.r.wb_val  = q.pc + 32'd4;
			e.r.next_pc = (a + ii) & 32'hFFFF_FFFE;
		end
		7'b0110111: begin
			e.r.rd_we  = 1'b1;
			e.r.wb_val = iu;
		end
		7'b0010111: begin
			e.r.rd_we  = 1'b1;
			e.r.wb_val = q.pc + iu;
		end
		7'b1110011: begin
			if (f3 == 3'd0 && ins[31:21] == 11'd0)
				e.r.exc = ins[20] ? EXC_EBREAK : EXC_ECALL;
			else
				ill = 1'b1;
		end
		default: ill = 1'b1;
	endcase
	if (ill) begin
		e.r.exc     = EXC_ILLEGAL;
		e.r.rd_we   = 1'b0;
		e.r.mem_op  = MEM_NONE;
		e.r.next_pc = q.pc + 32'd4;
		e.chk_wb    = 1'b0;
	end
	e.chk_wb = e.chk_wb || e.r.rd_we;
	return e;
endfunction

task automatic add_req(input logic [31:0] instr, input logic [31:0] a, input logic [31:0] b);
	exec_req_t q;
	q.instr   = instr;
	q.pc      = $urandom & 32'h00FF_FFFC;
	q.rs1_val = a;
	q.rs2_val = b;
	req_q.push_back(q);
	exp_q.push_back(ref_exec(q));
endtask

task automatic check_val(input string name, input logic [31:0] e, input logic [31:0] a);
	if (e !== a) begin
		$display("** Error: %s expected 0x%08h got 0x%08h", name, e, a);
		errors++;
	end
endtask

task automatic compare_exc(input exc_e e, input exc_e a);
	if (e !== a) begin
		$display("** Error: o_res.exc expected 0x%01h got 0x%01h", e, a);
		errors++;
	end
endtask

task automatic compare_res(input exp_t e, input exec_res_t a);
	if (e.chk_wb)
		check_val("o_res.wb_val", e.r.wb_val, a.wb_val);
	check_val("o_res.rd", 32'(e.r.rd), 32'(a.rd));
	check_val("o_res.rd_we", 32'(e.r.rd_we), 32'(a.rd_we));
	check_val("o_res.next_pc", e.r.next_pc, a.next_pc);
	check_val("o_res.mem_op", 32'(e.r.mem_op), 32'(a.mem_op));
	check_val("o_res.store_data", e.r.store_data, a.store_data);
	compare_exc(e.r.exc, a.exc);
endtask

// sample at negedge, drive on the next rising edge
// result credits are held back for the first withhold cycles
task automatic run_stream(input int withhold, output int first_lat, output int n_cr);
	int        n_total, n_sent, n_got, n_pend, req_cr, iter, send_it;
	logic      snd, ret;
	exec_req_t r;
	n_total   = req_q.size();
	n_sent    = 0;
	n_got     = 0;
	n_pend    = 0;
	n_cr      = 0;
	req_cr    = REQ_DEPTH;
	iter      = 0;
	send_it   = 0;
	first_lat = -1;
	r         = '0;
	while (n_got < n_total && iter < withhold + 200) begin
		@(negedge i_clk);
		if (o_req_credit) begin
			req_cr++;
			n_cr++;
		end
		if (o_res_valid) begin
			if (exp_q.size() == 0) begin
				$display("a result arrived with no request pending");
				errors++;
			end else begin
				compare_res(exp_q.pop_front(), o_res);
			end
			// edge of o_res_valid minus the edge that accepted the request
			if (n_got == 0)
				first_lat = (iter - 1) - (send_it + 1);
			n_got++;
			n_pend++;
		end
		if (withhold > 0 && iter == withhold && n_got != RES_CREDITS) begin
			$display("%0d results came out while credits were withheld, %0d allowed",
				n_got, RES_CREDITS);
			errors++;
		end
		ret = iter >= withhold && n_pend > 0;
		snd = n_sent < n_total && req_cr > 0;
		if (ret)
			n_pend--;
		if (snd) begin
			r = req_q.pop_front();
			req_cr--;
			if (n_sent == 0)
				send_it = iter;
			n_sent++;
		end
		@(posedge i_clk);
		i_req_valid  <= snd;
		i_req        <= r;
		i_res_credit <= ret;
		iter++;
	end
	if (n_got < n_total) begin
		$display("timed out with %0d of %0d results received", n_got, n_total);
		errors++;
		req_q.delete();
		exp_q.delete();
	end
	// hand back the last credits
	while (n_pend > 0) begin
		@(posedge i_clk);
		i_req_valid  <= 1'b0;
		i_res_credit <= 1'b1;
		n_pend--;
	end
	@(posedge i_clk);
	i_req_valid  <= 1'b0;
	i_res_credit <= 1'b0;
endtask

task automatic end_test(input string name, input int err0);
	tests_run++;
	if (errors > err0)
		tests_failed++;
	$display("test %-18s %s (%0d errors)", name, (errors > err0) ? "failed" : "ok", errors - err0);
endtask

task automatic test_alu_ops();
	int          err0, lat, n_cr;
	logic [31:0] a, b;
	err0 = errors;
	for (int f3 = 0; f3 < 8; f3++) begin
		// negative rs1 so slt and sltu disagree
		a = $urandom | 32'h8000_0000;
		b = $urandom & 32'h7FFF_FFFF;
		add_req(enc_r(7'h00, 3'(f3)), a, b);
		add_req(enc_i(12'($urandom), 3'(f3), 7'b0010011), a, b);
	end
	add_req(enc_r(7'h20, 3'd0), $urandom, $urandom);
	add_req(enc_r(7'h20, 3'd5), $urandom | 32'h8000_0000, $urandom);
	add_req(enc_i({7'h00, 5'($urandom)}, 3'd1, 7'b0010011), $urandom, 0);
	add_req(enc_i({7'h00, 5'($urandom)}, 3'd5, 7'b0010011), $urandom | 32'h8000_0000, 0);
	add_req(enc_i({7'h20, 5'($urandom)}, 3'd5, 7'b0010011), $urandom | 32'h8000_0000, 0);
	run_stream(0, lat, n_cr);
	end_test("alu_ops", err0);
endtask

task automatic test_branch_jump();
	int          err0, lat, n_cr;
	logic [31:0] x;
	logic [2:0]  conds[6];
	err0  = errors;
	conds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
	foreach (conds[i]) begin
		x = $urandom & 32'h7FFF_FFFE;
		add_req(enc_b(13'h0F0, conds[i]), x, x);
		add_req(enc_b(13'h1F20, conds[i]), x, x + 1);
		add_req(enc_b(13'h044, conds[i]), 32'hFFFF_FFFF, 32'd1);
		add_req(enc_b(13'h044, conds[i]), 32'd1, 32'hFFFF_FFFF);
	end
	add_req(enc_j(21'h0_1234 & 21'h1F_FFFE), 0, 0);
	add_req(enc_j(21'h1F_F000), 0, 0);
	// odd sum checks the cleared low bit
	add_req(enc_i(12'h005, 3'd0, 7'b1100111), $urandom & 32'hFFFF_FFF0, 0);
	add_req(enc_i(12'hFF3, 3'd0, 7'b1100111), $urandom, 0);
	run_stream(0, lat, n_cr);
	end_test("branch_jump", err0);
endtask

task automatic test_upper_mem();
	int          err0, lat, n_cr;
	logic [2:0]  ld[5];
	err0 = errors;
	ld   = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
	add_req({20'($urandom), 5'd5, 7'b0110111}, 0, 0);
	add_req({20'($urandom), 5'd5, 7'b0010111}, 0, 0);
	foreach (ld[i])
		add_req(enc_i(12'($urandom), ld[i], 7'b0000011), $urandom, $urandom);
	for (int f3 = 0; f3 < 3; f3++)
		add_req(enc_s(12'($urandom), 3'(f3)), $urandom, $urandom);
	run_stream(0, lat, n_cr);
	end_test("upper_mem", err0);
endtask

task automatic test_exceptions();
	int err0, lat, n_cr;
	err0 = errors;
	add_req(32'h0000_02FF, $urandom, $urandom);
	// funct7 0000001 is mul, not decoded here
	add_req(enc_r(7'h01, 3'd0), $urandom, $urandom);
	add_req(32'h0000_0073, $urandom, $urandom);
	add_req(32'h0010_0073, $urandom, $urandom);
	run_stream(0, lat, n_cr);
	end_test("exceptions", err0);
endtask

task automatic test_backpressure();
	int err0, lat, n_cr;
	err0 = errors;
	for (int i = 0; i < 8; i++)
		add_req(enc_r(7'h00, 3'(i)), $urandom, $urandom);
	run_stream(40, lat, n_cr);
	if (n_cr != 8) begin
		$display("saw %0d request credit pulses for 8 requests", n_cr);
		errors++;
	end
	end_test("backpressure", err0);
endtask

task automatic test_throughput();
	int err0, lat, n_cr;
	err0 = errors;
	for (int i = 0; i < 6; i++)
		add_req(enc_i(12'($urandom), 3'd0, 7'b0010011), $urandom, $urandom);
	run_stream(0, lat, n_cr);
	if (lat != 3) begin
		$display("first result came %0d cycles after acceptance instead of 3", lat);
		errors++;
	end
	end_test("throughput", err0);
endtask

// File: test/tb_rv_exec.sv
`timescale 1ns/1ps

module tb_rv_exec
	import rv_exec_pkg::*;
;
	localparam int REQ_DEPTH   = 2;
	localparam int RES_CREDITS = 2;

	// expected result plus a flag for whether wb_val is meaningful
	typedef struct packed {
		exec_res_t r;
		logic      chk_wb;
	} exp_t;

	logic      i_clk;
	logic      i_rst;
	logic      i_req_valid;
	exec_req_t i_req;
	logic      i_res_credit;
	logic      o_req_credit;
	logic      o_res_valid;
	exec_res_t o_res;

	// pending stimulus and the matching model results, in order
	exec_req_t req_q[$];
	exp_t      exp_q[$];

	int errors;
	int tests_run;
	int tests_failed;

	rv_exec_top #(
		.REQ_DEPTH  (REQ_DEPTH),
		.RES_CREDITS(RES_CREDITS)
	) dut0 (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_req_valid (i_req_valid),
		.i_req       (i_req),
		.i_res_credit(i_res_credit),
		.o_req_credit(o_req_credit),
		.o_res_valid (o_res_valid),
		.o_res       (o_res)
	);

	// 100 ns period
	always #50 i_clk = ~i_clk;

	`include "tb_rv_exec_tasks.svh"

	initial begin
		i_clk        = 1'b0;
		i_rst        = 1'b1;
		i_req_valid  = 1'b0;
		i_req        = '0;
		i_res_credit = 1'b0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		void'($urandom(50058));
		// reset held for 4 cycles
		repeat (4) @(posedge i_clk);
		i_rst <= 1'b0;
		@(posedge i_clk);
		test_alu_ops();
		test_branch_jump();
		test_upper_mem();
		test_exceptions();
		test_backpressure();
		test_throughput();
		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: src/rv_exec_top.sv
`timescale 1ns/1ps

module rv_exec_top
	import rv_exec_pkg::*;
#(
	parameter int REQ_DEPTH   = 2,
	parameter int RES_CREDITS = 2
) (
	input  logic      i_clk,
	input  logic      i_rst,
	input  logic      i_req_valid,
	input  exec_req_t i_req,
	input  logic      i_res_credit,
	output logic      o_req_credit,
	output logic      o_res_valid,
	output exec_res_t o_res
);
	// stage links
	logic      advance;
	logic      dec_valid;
	dec_ctrl_t dec;
	logic      exe_valid;
	exe_out_t  exe;

	// queue, decode, decode register
	instr_decoder #(
		.REQ_DEPTH(REQ_DEPTH)
	) u_decode (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_req_valid (i_req_valid),
		.i_req       (i_req),
		.i_advance   (advance),
		.o_req_credit(o_req_credit),
		.o_dec_valid (dec_valid),
		.o_dec       (dec)
	);

	// alu, branch, next pc
	alu_execute u_execute (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_advance  (advance),
		.i_dec_valid(dec_valid),
		.i_dec      (dec),
		.o_exe_valid(exe_valid),
		.o_exe      (exe)
	);

	// result mux and output credits, source of advance
	writeback_select #(
		.RES_CREDITS(RES_CREDITS)
	) u_result (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_exe_valid (exe_valid),
		.i_exe       (exe),
		.i_res_credit(i_res_credit),
		.o_advance   (advance),
		.o_res_valid (o_res_valid),
		.o_res       (o_res)
	);

endmodule

// File: src/writeback_select.sv
`timescale 1ns/1ps

module writeback_select
	import rv_exec_pkg::*;
#(
	parameter int RES_CREDITS = 2
) (
	input  logic      i_clk,
	input  logic      i_rst,
	input  logic      i_exe_valid,
	input  exe_out_t  i_exe,
	input  logic      i_res_credit,
	output logic      o_advance,
	output logic      o_res_valid,
	output exec_res_t o_res
);
	localparam int CNT_W = $clog2(RES_CREDITS + 1);

	logic [CNT_W-1:0] credit_cnt;
	logic             fire;
	logic [31:0]      wb_val;
	exec_res_t        res;

	// whole pipe moves only while a result slot is free
	assign o_advance = credit_cnt != '0;
	assign fire      = i_exe_valid && o_advance;

	always_comb begin
		case (i_exe.wb_sel)
			WB_ALU:   wb_val = i_exe.alu_val;
			WB_PC4:   wb_val = i_exe.pc4;
			WB_IMM:   wb_val = i_exe.imm_val;
			WB_AUIPC: wb_val = i_exe.auipc_val;
			// no data memory, a load returns its address
			WB_LOAD:  wb_val = i_exe.alu_val;
			default:  wb_val = i_exe.alu_val;
		endcase
	end

	always_comb begin
		res.wb_val     = wb_val;
		res.rd         = i_exe.rd;
		res.rd_we      = i_exe.rd_we;
		res.next_pc    = i_exe.next_pc;
		res.mem_op     = i_exe.mem_op;
		res.store_data = i_exe.store_data;
		res.exc        = i_exe.exc;
	end

	// result credits, send and return in one cycle cancel out
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			credit_cnt  <= CNT_W'(RES_CREDITS);
			o_res_valid <= 1'b0;
		end else begin
			case ({fire, i_res_credit})
				2'b10:   credit_cnt <= credit_cnt - 1'b1;
				2'b01:   credit_cnt <= credit_cnt + 1'b1;
				default: credit_cnt <= credit_cnt;
			endcase
			o_res_valid <= fire;
		end
	end

	always_ff @(posedge i_clk) begin
		if (fire)
			o_res <= res;
	end

endmodule

// File: src/alu_execute.sv
`timescale 1ns/1ps

module alu_execute
	import rv_exec_pkg::*;
(
	input  logic      i_clk,
	input  logic      i_rst,
	input  logic      i_advance,
	input  logic      i_dec_valid,
	input  dec_ctrl_t i_dec,
	output logic      o_exe_valid,
	output exe_out_t  o_exe
);
	logic [31:0] op_a, op_b;
	logic [4:0]  shamt;
	logic [31:0] alu_res;
	logic        cmp_eq, cmp_lt, cmp_ltu;
	logic        taken;
	logic [31:0] pc4, pc_imm, jalr_sum, next_pc;
	exe_out_t    eo;

	// operand b, register or immediate
	assign op_a  = i_dec.rs1_val;
	assign op_b  = i_dec.b_sel_imm ? i_dec.imm : i_dec.rs2_val;
	assign shamt = op_b[4:0];

	always_comb begin
		case (i_dec.alu_op)
			ALU_ADD:  alu_res = op_a + op_b;
			ALU_SUB:  alu_res = op_a - op_b;
			ALU_SLL:  alu_res = op_a << shamt;
			ALU_SLT:  alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
			ALU_SLTU: alu_res = {31'b0, op_a < op_b};
			ALU_XOR:  alu_res = op_a ^ op_b;
			ALU_SRL:  alu_res = op_a >> shamt;
			ALU_SRA:  alu_res = $signed(op_a) >>> shamt;
			ALU_OR:   alu_res = op_a | op_b;
			ALU_AND:  alu_res = op_a & op_b;
			// branch compare codes, not written back
			ALU_BGE:  alu_res = {31'b0, $signed(op_a) >= $signed(op_b)};
			ALU_BGEU: alu_res = {31'b0, op_a >= op_b};
			default:  alu_res = '0;
		endcase
	end

	// branch comparator, always rs1 against rs2
	assign cmp_eq  = i_dec.rs1_val == i_dec.rs2_val;
	assign cmp_lt  = $signed(i_dec.rs1_val) < $signed(i_dec.rs2_val);
	assign cmp_ltu = i_dec.rs1_val < i_dec.rs2_val;

	always_comb begin
		case (i_dec.br_cond)
			BR_EQ:   taken = cmp_eq;
			BR_NE:   taken = !cmp_eq;
			BR_LT:   taken = cmp_lt;
			BR_GE:   taken = !cmp_lt;
			BR_LTU:  taken = cmp_ltu;
			BR_GEU:  taken = !cmp_ltu;
			default: taken = 1'b0;
		endcase
	end

	// next pc, jalr first, then jal / taken branch
	assign pc4      = i_dec.pc + 32'd4;
	assign pc_imm   = i_dec.pc + i_dec.imm;
	assign jalr_sum = i_dec.rs1_val + i_dec.imm;

	always_comb begin
		if (i_dec.jalr)
			next_pc = {jalr_sum[31:1], 1'b0};
		else if (i_dec.jal || taken)
			next_pc = pc_imm;
		else
			next_pc = pc4;
	end

	always_comb begin
		// load/store address comes out of the adder
		eo.alu_val    = alu_res;
		eo.pc4        = pc4;
		eo.imm_val    = i_dec.imm;
		eo.auipc_val  = pc_imm;
		eo.next_pc    = next_pc;
		eo.store_data = i_dec.rs2_val;
		eo.wb_sel     = i_dec.wb_sel;
		eo.mem_op     = i_dec.mem_op;
		eo.exc        = i_dec.exc;
		eo.rd_we      = i_dec.rd_we;
		eo.rd         = i_dec.rd;
	end

	// execute stage register, holds while stalled
	always_ff @(posedge i_clk) begin
		if (i_rst)
			o_exe_valid <= 1'b0;
		else if (i_advance)
			o_exe_valid <= i_dec_valid;
	end

	always_ff @(posedge i_clk) begin
		if (i_advance)
			o_exe <= eo;
	end

endmodule

// File: src/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder
	import rv_exec_pkg::*;
#(
	parameter int REQ_DEPTH = 2
) (
	input  logic      i_clk,
	input  logic      i_rst,
	input  logic      i_req_valid,
	input  exec_req_t i_req,
	input  logic      i_advance,
	output logic      o_req_credit,
	output logic      o_dec_valid,
	output dec_ctrl_t o_dec
);
	localparam int PTR_W = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;
	localparam int CNT_W = $clog2(REQ_DEPTH + 1);

	exec_req_t        q_mem [REQ_DEPTH];
	logic [PTR_W-1:0] wr_ptr, rd_ptr;
	logic [CNT_W-1:0] q_cnt;
	logic             pop;

	exec_req_t   head;
	logic [31:0] instr;
	opcode_e     opcode;
	logic [2:0]  funct3;
	logic [6:0]  funct7;
	logic [11:0] funct12;
	logic        instr_30;
	logic        illegal;
	logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;
	dec_ctrl_t   dc;

	// head leaves only when the whole pipe moves
	assign pop = i_advance && (q_cnt != '0);

	// queue pointers and fill level
	// sender never pushes without a credit, so no full check
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			wr_ptr       <= '0;
			rd_ptr       <= '0;
			q_cnt        <= '0;
			o_req_credit <= 1'b0;
		end else begin
			if (i_req_valid)
				wr_ptr <= (wr_ptr == PTR_W'(REQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(REQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({i_req_valid, pop})
				2'b10:   q_cnt <= q_cnt + 1'b1;
				2'b01:   q_cnt <= q_cnt - 1'b1;
				default: q_cnt <= q_cnt;
			endcase
			// one credit back per entry handed to decode
			o_req_credit <= pop;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_req_valid)
			q_mem[wr_ptr] <= i_req;
	end

	// instruction fields
	assign head     = q_mem[rd_ptr];
	assign instr    = head.instr;
	assign opcode   = opcode_e'(instr[6:0]);
	assign funct3   = instr[14:12];
	assign funct7   = instr[31:25];
	assign funct12  = instr[31:20];
	assign instr_30 = instr[30];

	// immediate formats
	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		// all enum defaults are the zero code
		dc         = '0;
		dc.pc      = head.pc;
		dc.rs1_val = head.rs1_val;
		dc.rs2_val = head.rs2_val;
		dc.rd      = instr[11:7];
		illegal    = 1'b0;
		case (opcode)
			OPC_OP: begin
				dc.rd_we  = 1'b1;
				dc.alu_op = alu_op_e'({instr_30, funct3});
				// funct7 0100000 only for sub and sra
				if (funct7 != 7'b0000000 &&
				    !(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)))
					illegal = 1'b1;
			end
			OPC_OP_IMM: begin
				dc.rd_we     = 1'b1;
				dc.b_sel_imm = 1'b1;
				dc.imm       = imm_i;
				dc.alu_op    = alu_op_e'({1'b0, funct3});
				// shifts keep funct7, bit 30 picks srai
				if (funct3 == 3'b101) begin
					dc.alu_op = alu_op_e'({instr_30, funct3});
					if (funct7 != 7'b0000000 && funct7 != 7'b0100000)
						illegal = 1'b1;
				end else if (funct3 == 3'b001 && funct7 != 7'b0000000) begin
					illegal = 1'b1;
				end
			end
			OPC_LOAD: begin
				dc.rd_we     = 1'b1;
				dc.b_sel_imm = 1'b1;
				dc.imm       = imm_i;
				dc.wb_sel    = WB_LOAD;
				case (funct3)
					3'b000:  dc.mem_op = MEM_LB;
					3'b001:  dc.mem_op = MEM_LH;
					3'b010:  dc.mem_op = MEM_LW;
					3'b100:  dc.mem_op = MEM_LBU;
					3'b101:  dc.mem_op = MEM_LHU;
					default: illegal = 1'b1;
				endcase
			end
			OPC_STORE: begin
				dc.b_sel_imm = 1'b1;
				dc.imm       = imm_s;
				case (funct3)
					3'b000:  dc.mem_op = MEM_SB;
					3'b001:  dc.mem_op = MEM_SH;
					3'b010:  dc.mem_op = MEM_SW;
					default: illegal = 1'b1;
				endcase
			end
			OPC_BRANCH: begin
				dc.imm = imm_b;
				// alu code follows the compare, as in the base scheme
				case (funct3)
					3'b000: begin
						dc.br_cond = BR_EQ;
						dc.alu_op  = ALU_SUB;
					end
					3'b001: begin
						dc.br_cond = BR_NE;
						dc.alu_op  = ALU_SUB;
					end
					3'b100: begin
						dc.br_cond = BR_LT;
						dc.alu_op  = ALU_SLT;
					end
					3'b101: begin
						dc.br_cond = BR_GE;
						dc.alu_op  = ALU_BGE;
					end
					3'b110: begin
						dc.br_cond = BR_LTU;
						dc.alu_op  = ALU_SLTU;
					end
					3'b111: begin
						dc.br_cond = BR_GEU;
						dc.alu_op  = ALU_BGEU;
					end
					default: illegal = 1'b1;
				endcase
			end
			OPC_JAL: begin
				dc.jal    = 1'b1;
				dc.rd_we  = 1'b1;
				dc.imm    = imm_j;
				dc.wb_sel = WB_PC4;
			end
			OPC_JALR: begin
				dc.jalr   = 1'b1;
				dc.rd_we  = 1'b1;
				dc.imm    = imm_i;
				dc.wb_sel = WB_PC4;
				if (funct3 != 3'b000)
					illegal = 1'b1;
			end
			OPC_LUI: begin
				dc.rd_we  = 1'b1;
				dc.imm    = imm_u;
				dc.wb_sel = WB_IMM;
			end
			OPC_AUIPC: begin
				dc.rd_we  = 1'b1;
				dc.imm    = imm_u;
				dc.wb_sel = WB_AUIPC;
			end
			OPC_SYSTEM: begin
				// only ecall / ebreak, funct12[0] tells them apart
				if (funct3 != 3'b000 || funct12[11:1] != 11'b0)
					illegal = 1'b1;
				else
					dc.exc = funct12[0] ? EXC_EBREAK : EXC_ECALL;
			end
			default: illegal = 1'b1;
		endcase
		// illegal kills every side effect
		if (illegal) begin
			dc.exc     = EXC_ILLEGAL;
			dc.rd_we   = 1'b0;
			dc.mem_op  = MEM_NONE;
			dc.br_cond = BR_NONE;
			dc.jalr    = 1'b0;
		end
	end

	// decode stage register
	always_ff @(posedge i_clk) begin
		if (i_rst)
			o_dec_valid <= 1'b0;
		else if (i_advance)
			o_dec_valid <= pop;
	end

	always_ff @(posedge i_clk) begin
		if (pop)
			o_dec <= dc;
	end

endmodule

// File: src/rv_exec_pkg.sv
package rv_exec_pkg;

	// rv32i major opcodes, instr[6:0]
	typedef enum logic [6:0] {
		OPC_LOAD   = 7'b0000011,
		OPC_OP_IMM = 7'b0010011,
		OPC_AUIPC  = 7'b0010111,
		OPC_STORE  = 7'b0100011,
		OPC_OP     = 7'b0110011,
		OPC_LUI    = 7'b0110111,
		OPC_BRANCH = 7'b1100011,
		OPC_JALR   = 7'b1100111,
		OPC_JAL    = 7'b1101111,
		OPC_SYSTEM = 7'b1110011
	} opcode_e;

	// alu function code, {instr[30], funct3}
	// bge and bgeu take the free slots 1001 and 1010
	typedef enum logic [3:0] {
		ALU_ADD  = 4'b0000,
		ALU_SLL  = 4'b0001,
		ALU_SLT  = 4'b0010,
		ALU_SLTU = 4'b0011,
		ALU_XOR  = 4'b0100,
		ALU_SRL  = 4'b0101,
		ALU_OR   = 4'b0110,
		ALU_AND  = 4'b0111,
		ALU_SUB  = 4'b1000,
		ALU_BGE  = 4'b1001,
		ALU_BGEU = 4'b1010,
		ALU_SRA  = 4'b1101
	} alu_op_e;

	typedef enum logic [2:0] {
		BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
	} br_cond_e;

	// write-back source
	typedef enum logic [2:0] {
		WB_ALU   = 3'b000,
		WB_PC4   = 3'b001,
		WB_IMM   = 3'b011,
		WB_AUIPC = 3'b100,
		WB_LOAD  = 3'b111
	} wb_sel_e;

	// memory op codes, stores have bit 3 set
	typedef enum logic [3:0] {
		MEM_NONE = 4'b0000,
		MEM_LB   = 4'b0001,
		MEM_LH   = 4'b0010,
		MEM_LW   = 4'b0011,
		MEM_LBU  = 4'b0100,
		MEM_LHU  = 4'b0101,
		MEM_SB   = 4'b1110,
		MEM_SH   = 4'b1111,
		MEM_SW   = 4'b1000
	} mem_op_e;

	typedef enum logic [1:0] {
		EXC_NONE, EXC_ILLEGAL, EXC_ECALL, EXC_EBREAK
	} exc_e;

	// one request from the sender, 128 bits
	typedef struct packed {
		logic [31:0] instr;
		logic [31:0] pc;
		logic [31:0] rs1_val;
		logic [31:0] rs2_val;
	} exec_req_t;

	// decode to execute
	typedef struct packed {
		alu_op_e     alu_op;
		br_cond_e    br_cond;
		wb_sel_e     wb_sel;
		mem_op_e     mem_op;
		exc_e        exc;
		logic        b_sel_imm;
		logic        jal;
		logic        jalr;
		logic        rd_we;
		logic [31:0] imm;
		logic [31:0] pc;
		logic [31:0] rs1_val;
		logic [31:0] rs2_val;
		logic [4:0]  rd;
	} dec_ctrl_t;

	// execute to result
	typedef struct packed {
		logic [31:0] alu_val;
		logic [31:0] pc4;
		logic [31:0] imm_val;
		logic [31:0] auipc_val;
		logic [31:0] next_pc;
		logic [31:0] store_data;
		wb_sel_e     wb_sel;
		mem_op_e     mem_op;
		exc_e        exc;
		logic        rd_we;
		logic [4:0]  rd;
	} exe_out_t;

	// result to the consumer
	typedef struct packed {
		logic [31:0] wb_val;
		logic [4:0]  rd;
		logic        rd_we;
		logic [31:0] next_pc;
		mem_op_e     mem_op;
		logic [31:0] store_data;
		exc_e        exc;
	} exec_res_t;

endpackage
